// File: src/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// width of a bus address
`define BUS_ADDR_W 8

// width of a bus data word
`define BUS_DATA_W 32

// words held by the memory target, indexed by the low address bits
`define BUS_MEM_WORDS 16

// cycles from ts to aack at the target
`define BUS_ACK_LATENCY 2

// cycles after a write beat during which new address tenures are retried
`define BUS_WRITE_BUSY 4

`endif

// File: src/bus_pkg.sv
`default_nettype none

`include "bus_config.svh"

package bus_pkg;

	// an address as it travels on the shared address bus
	typedef logic [`BUS_ADDR_W-1:0] addr_t;

	// a data word as it travels on the shared data bus
	typedef logic [`BUS_DATA_W-1:0] data_t;

	// names master 0 or master 1
	typedef logic [0:0] master_id_t;

	// address arbiter states
	// the idle states remember which master owned the bus last
	typedef enum logic [2:0] {
		idle_0,
		idle_1,
		granted_0,
		granted_0_aack,
		granted_1,
		granted_1_aack
	} arb_state_t;

	// per-master transaction states, one transaction at a time
	typedef enum logic [1:0] {idle, request, addr_wait, data_wait} tenure_state_t;

endpackage

`default_nettype wire

// File: src/addr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module addr_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic br0,
	input  logic br1,
	input  logic ts,
	input  logic aack,
	input  logic artry,
	output logic bg0,
	output logic bg1
);

	bus_pkg::arb_state_t state;
	bus_pkg::arb_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			bus_pkg::idle_0, bus_pkg::idle_1: begin
				if (artry) begin
					// a retry is in flight, so keep the grant where it is
					// and let the retried master ask again
					state_nxt = state;
				end else if (ts) begin
					// the last owner used its grant from the aack window to
					// start a parked transfer, so track that tenure as granted
					state_nxt = (state == bus_pkg::idle_0) ? bus_pkg::granted_0 :
						bus_pkg::granted_1;
				end else if (br0 && !br1) begin
					state_nxt = bus_pkg::granted_0;
				end else if (br1 && !br0) begin
					state_nxt = bus_pkg::granted_1;
				end else if (!br0 && !br1) begin
					state_nxt = state;
				end else begin
					// both masters want the bus: hand it to the one that
					// did not own it last time
					state_nxt = (state == bus_pkg::idle_0) ? bus_pkg::granted_1 :
						bus_pkg::granted_0;
				end
			end
			bus_pkg::granted_0: begin
				if (aack) begin
					state_nxt = bus_pkg::granted_0_aack;
				end
			end
			bus_pkg::granted_0_aack: begin
				// one cycle in which the owner may park another start
				state_nxt = bus_pkg::idle_0;
			end
			bus_pkg::granted_1: begin
				if (aack) begin
					state_nxt = bus_pkg::granted_1_aack;
				end
			end
			bus_pkg::granted_1_aack: begin
				state_nxt = bus_pkg::idle_1;
			end
			default: begin
				state_nxt = bus_pkg::idle_1;
			end
		endcase
	end

	// idle_1 after reset means master 0 wins the first tie
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bus_pkg::idle_1;
		end else begin
			state <= state_nxt;
		end
	end

	// the grant stays up through the aack state so the owner can park
	assign bg0 = (state == bus_pkg::granted_0) || (state == bus_pkg::granted_0_aack);
	assign bg1 = (state == bus_pkg::granted_1) || (state == bus_pkg::granted_1_aack);

endmodule

`default_nettype wire

// File: src/data_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module data_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic aack,
	input  logic artry,
	input  logic bg0,
	input  logic ta,
	output logic dbg0,
	output logic dbg1
);

	// with one transaction per master, two entries never overflow
	bus_pkg::master_id_t fifo [2];
	bus_pkg::master_id_t push_id;
	logic rd_ptr;
	logic wr_ptr;
	logic [1:0] count;
	logic push;

	// an address tenure is accepted when aack comes without artry
	assign push = aack && !artry;

	// the address owner is whoever holds the address grant at aack time
	assign push_id = bus_pkg::master_id_t'(!bg0);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= 1'b0;
			wr_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= !wr_ptr;
			end
			// every ta ends the data tenure at the head
			if (ta) begin
				rd_ptr <= !rd_ptr;
			end
			case ({push, ta})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo[wr_ptr] <= push_id;
		end
	end

	// data grants follow the order in which address tenures were accepted
	assign dbg0 = (count != 2'd0) && (fifo[rd_ptr] == bus_pkg::master_id_t'(0));
	assign dbg1 = (count != 2'd0) && (fifo[rd_ptr] == bus_pkg::master_id_t'(1));

endmodule

`default_nettype wire

// File: src/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmd_valid,
	input  logic                cmd_write,
	input  bus_pkg::addr_t      cmd_addr,
	input  bus_pkg::data_t      cmd_wdata,
	input  logic                bg,
	input  logic                aack,
	input  logic                artry,
	input  logic                dbg,
	input  logic                ta,
	input  bus_pkg::data_t      bus_rdata,
	output logic                busy,
	output logic                done,
	output bus_pkg::data_t      rdata,
	output logic                br,
	output logic                ts,
	output logic                write,
	output bus_pkg::addr_t      addr,
	output bus_pkg::data_t      wdata
);

	bus_pkg::tenure_state_t state;
	logic write_q;
	bus_pkg::addr_t addr_q;
	bus_pkg::data_t wdata_q;
	logic ts_q;
	logic beat;

	// ta belongs to this master only while its data grant is up
	assign beat = (state == bus_pkg::data_wait) && dbg && ta;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bus_pkg::idle;
			ts_q <= 1'b0;
			done <= 1'b0;
		end else begin
			ts_q <= 1'b0;
			done <= 1'b0;
			case (state)
				bus_pkg::idle: begin
					// a command while busy is never seen here and is dropped
					if (cmd_valid) begin
						if (bg) begin
							// grant already parked on us, start without asking
							ts_q <= 1'b1;
							state <= bus_pkg::addr_wait;
						end else begin
							state <= bus_pkg::request;
						end
					end
				end
				bus_pkg::request: begin
					if (bg) begin
						ts_q <= 1'b1;
						state <= bus_pkg::addr_wait;
					end
				end
				bus_pkg::addr_wait: begin
					// a retry cancels the tenure and we ask for the bus again
					if (aack) begin
						state <= artry ? bus_pkg::request : bus_pkg::data_wait;
					end
				end
				bus_pkg::data_wait: begin
					if (beat) begin
						done <= 1'b1;
						state <= bus_pkg::idle;
					end
				end
				default: begin
					state <= bus_pkg::idle;
				end
			endcase
		end
	end

	// command payload is captured once and held for all retries
	always_ff @(posedge clk) begin
		if ((state == bus_pkg::idle) && cmd_valid) begin
			write_q <= cmd_write;
			addr_q <= cmd_addr;
			wdata_q <= cmd_wdata;
		end
		if (beat && !write_q) begin
			rdata <= bus_rdata;
		end
	end

	assign busy = (state != bus_pkg::idle);
	assign br = (state == bus_pkg::request);
	assign ts = ts_q;

	// drive zeros when idle so the top level can OR both masters
	assign addr = ts_q ? addr_q : '0;
	assign write = ts_q && write_q;
	assign wdata = ((state == bus_pkg::data_wait) && dbg && write_q) ? wdata_q : '0;

endmodule

`default_nettype wire

// File: src/bus_target.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_target (
	input  logic           clk,
	input  logic           rst,
	input  logic           ts,
	input  logic           write,
	input  bus_pkg::addr_t addr,
	input  logic           dbg,
	input  bus_pkg::data_t wdata,
	output logic           aack,
	output logic           artry,
	output logic           ta,
	output bus_pkg::data_t rdata
);

	localparam int idx_w = $clog2(`BUS_MEM_WORDS);
	localparam int lat_w = $clog2(`BUS_ACK_LATENCY + 1);
	localparam int busy_w = $clog2(`BUS_WRITE_BUSY + 1);

	bus_pkg::data_t mem [`BUS_MEM_WORDS];
	logic [lat_w-1:0] lat_cnt;
	logic [busy_w-1:0] busy_cnt;
	bus_pkg::addr_t pend_addr;
	logic pend_write;
	bus_pkg::addr_t q_addr [2];
	logic q_write [2];
	logic q_rd_ptr;
	logic q_wr_ptr;
	logic accept;
	logic [idx_w-1:0] head_idx;

	// aack lands exactly BUS_ACK_LATENCY cycles after ts
	assign aack = (lat_cnt == lat_w'(1));

	// while a recent write is still settling, new tenures are bounced
	assign artry = aack && (busy_cnt != '0);
	assign accept = aack && !artry;

	// data beats are served in the order their addresses were accepted
	assign head_idx = q_addr[q_rd_ptr][idx_w-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			lat_cnt <= '0;
			busy_cnt <= '0;
			ta <= 1'b0;
			q_rd_ptr <= 1'b0;
			q_wr_ptr <= 1'b0;
			for (int i = 0; i < `BUS_MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (ts) begin
				lat_cnt <= lat_w'(`BUS_ACK_LATENCY);
			end else if (lat_cnt != '0) begin
				lat_cnt <= lat_cnt - lat_w'(1);
			end
			// one beat per data grant, never two in a row
			ta <= dbg && !ta;
			if (accept) begin
				q_wr_ptr <= !q_wr_ptr;
			end
			if (ta) begin
				q_rd_ptr <= !q_rd_ptr;
			end
			if (ta && q_write[q_rd_ptr]) begin
				mem[head_idx] <= wdata;
				busy_cnt <= busy_w'(`BUS_WRITE_BUSY);
			end else if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - busy_w'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		// the address phase is held until its aack decides its fate
		if (ts) begin
			pend_addr <= addr;
			pend_write <= write;
		end
		if (accept) begin
			q_addr[q_wr_ptr] <= pend_addr;
			q_write[q_wr_ptr] <= pend_write;
		end
		// read data is fetched the cycle before ta so it is valid with ta
		if (dbg && !ta && !q_write[q_rd_ptr]) begin
			rdata <= mem[head_idx];
		end
	end

endmodule

`default_nettype wire

// File: src/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top (
	input  logic           clk,
	input  logic           rst,
	input  logic           m0_cmd_valid,
	input  logic           m0_cmd_write,
	input  bus_pkg::addr_t m0_cmd_addr,
	input  bus_pkg::data_t m0_cmd_wdata,
	output logic           m0_busy,
	output logic           m0_done,
	output bus_pkg::data_t m0_rdata,
	input  logic           m1_cmd_valid,
	input  logic           m1_cmd_write,
	input  bus_pkg::addr_t m1_cmd_addr,
	input  bus_pkg::data_t m1_cmd_wdata,
	output logic           m1_busy,
	output logic           m1_done,
	output bus_pkg::data_t m1_rdata,
	output logic           bg0,
	output logic           bg1,
	output logic           artry,
	output logic           ts
);

	logic br0;
	logic br1;
	logic ts0;
	logic ts1;
	logic write0;
	logic write1;
	bus_pkg::addr_t addr0;
	bus_pkg::addr_t addr1;
	bus_pkg::data_t wdata0;
	bus_pkg::data_t wdata1;
	logic dbg0;
	logic dbg1;
	logic aack;
	logic ta;
	bus_pkg::data_t bus_rdata;

	// idle masters drive zeros, so the shared bus is a plain OR
	assign ts = ts0 | ts1;

	bus_master m0_i (
		.clk(clk), .rst(rst),
		.cmd_valid(m0_cmd_valid), .cmd_write(m0_cmd_write),
		.cmd_addr(m0_cmd_addr), .cmd_wdata(m0_cmd_wdata),
		.bg(bg0), .aack(aack), .artry(artry), .dbg(dbg0), .ta(ta),
		.bus_rdata(bus_rdata),
		.busy(m0_busy), .done(m0_done), .rdata(m0_rdata),
		.br(br0), .ts(ts0), .write(write0), .addr(addr0), .wdata(wdata0)
	);

	bus_master m1_i (
		.clk(clk), .rst(rst),
		.cmd_valid(m1_cmd_valid), .cmd_write(m1_cmd_write),
		.cmd_addr(m1_cmd_addr), .cmd_wdata(m1_cmd_wdata),
		.bg(bg1), .aack(aack), .artry(artry), .dbg(dbg1), .ta(ta),
		.bus_rdata(bus_rdata),
		.busy(m1_busy), .done(m1_done), .rdata(m1_rdata),
		.br(br1), .ts(ts1), .write(write1), .addr(addr1), .wdata(wdata1)
	);

	addr_arbiter addr_arb_i (
		.clk(clk), .rst(rst), .br0(br0), .br1(br1), .ts(ts),
		.aack(aack), .artry(artry), .bg0(bg0), .bg1(bg1)
	);

	// the data arbiter learns the owner of each accepted tenure from bg0
	data_arbiter data_arb_i (
		.clk(clk), .rst(rst), .aack(aack), .artry(artry), .bg0(bg0),
		.ta(ta), .dbg0(dbg0), .dbg1(dbg1)
	);

	bus_target target_i (
		.clk(clk), .rst(rst), .ts(ts), .write(write0 | write1),
		.addr(addr0 | addr1), .dbg(dbg0 | dbg1), .wdata(wdata0 | wdata1),
		.aack(aack), .artry(artry), .ta(ta), .rdata(bus_rdata)
	);

endmodule

`default_nettype wire

// File: bench/tb_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module tb_bus_top;

	localparam int idx_w = $clog2(`BUS_MEM_WORDS);
	localparam int n_entries = 51;
	localparam int timeout_cycles = n_entries * 40;

	// one table row, and whether the next row is issued in the same cycle
	typedef struct packed {
		logic           master;
		logic           write;
		bus_pkg::addr_t addr;
		bus_pkg::data_t wdata;
		logic           together;
	} entry_t;

	logic clk;
	logic rst;
	logic m0_cmd_valid;
	logic m0_cmd_write;
	bus_pkg::addr_t m0_cmd_addr;
	bus_pkg::data_t m0_cmd_wdata;
	logic m0_busy;
	logic m0_done;
	bus_pkg::data_t m0_rdata;
	logic m1_cmd_valid;
	logic m1_cmd_write;
	bus_pkg::addr_t m1_cmd_addr;
	bus_pkg::data_t m1_cmd_wdata;
	logic m1_busy;
	logic m1_done;
	bus_pkg::data_t m1_rdata;
	logic bg0;
	logic bg1;
	logic artry;
	logic ts;

	entry_t entries [n_entries];
	int entry_count;
	bus_pkg::data_t model_mem [`BUS_MEM_WORDS];
	logic [31:0] lfsr_state;
	logic last_owner;
	int cycle_count;

	bus_top dut_i (
		.clk(clk), .rst(rst),
		.m0_cmd_valid(m0_cmd_valid), .m0_cmd_write(m0_cmd_write),
		.m0_cmd_addr(m0_cmd_addr), .m0_cmd_wdata(m0_cmd_wdata),
		.m0_busy(m0_busy), .m0_done(m0_done), .m0_rdata(m0_rdata),
		.m1_cmd_valid(m1_cmd_valid), .m1_cmd_write(m1_cmd_write),
		.m1_cmd_addr(m1_cmd_addr), .m1_cmd_wdata(m1_cmd_wdata),
		.m1_busy(m1_busy), .m1_done(m1_done), .m1_rdata(m1_rdata),
		.bg0(bg0), .bg1(bg1), .artry(artry), .ts(ts)
	);

	always #4 clk = ~clk;

	task automatic check_data(input string name, input bus_pkg::data_t got,
			input bus_pkg::data_t expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// taps 32, 22, 2 and 1, shifted towards the msb
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken, newest bit at the lsb
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic busy_of(input logic m);
		return m ? m1_busy : m0_busy;
	endfunction

	function automatic logic done_of(input logic m);
		return m ? m1_done : m0_done;
	endfunction

	function automatic bus_pkg::data_t rdata_of(input logic m);
		return m ? m1_rdata : m0_rdata;
	endfunction

	task automatic add_entry(input logic m, input logic w, input bus_pkg::addr_t a,
			input bus_pkg::data_t d, input logic t);
		entries[entry_count] = '{master: m, write: w, addr: a, wdata: d, together: t};
		entry_count = entry_count + 1;
	endtask

	task automatic build_table();
		bus_pkg::addr_t a;
		bus_pkg::data_t d;
		logic w;
		logic t;
		// first reads see the cleared memory
		add_entry(1'b0, 1'b0, 8'h03, 32'h0, 1'b0);
		add_entry(1'b1, 1'b0, 8'h0c, 32'h0, 1'b0);
		add_entry(1'b0, 1'b1, 8'h02, 32'h1111_2222, 1'b0);
		add_entry(1'b0, 1'b1, 8'h05, 32'ha5a5_0f0f, 1'b0);
		add_entry(1'b1, 1'b1, 8'h09, 32'hdead_beef, 1'b0);
		add_entry(1'b0, 1'b0, 8'h02, 32'h0, 1'b0);
		add_entry(1'b0, 1'b0, 8'h05, 32'h0, 1'b0);
		add_entry(1'b1, 1'b0, 8'h09, 32'h0, 1'b0);
		// master 1 owned the bus last, so master 0 should win this tie
		add_entry(1'b0, 1'b0, 8'h05, 32'h0, 1'b1);
		add_entry(1'b1, 1'b0, 8'h09, 32'h0, 1'b0);
		add_entry(1'b0, 1'b1, 8'h44, 32'h0bad_f00d, 1'b0);
		// now master 0 owned it last and master 1 should win
		add_entry(1'b0, 1'b0, 8'h44, 32'h0, 1'b1);
		add_entry(1'b1, 1'b0, 8'h09, 32'h0, 1'b0);
		add_entry(1'b1, 1'b1, 8'h0a, 32'h5a5a_1234, 1'b0);
		// the write goes first and keeps the target busy for the read
		add_entry(1'b0, 1'b1, 8'h06, 32'h7777_0006, 1'b1);
		add_entry(1'b1, 1'b0, 8'h0a, 32'h0, 1'b0);
		// back to back on master 0 with master 1 quiet
		add_entry(1'b0, 1'b1, 8'h07, 32'h0000_cafe, 1'b0);
		add_entry(1'b0, 1'b0, 8'h07, 32'h0, 1'b0);
		add_entry(1'b0, 1'b0, 8'h06, 32'h0, 1'b0);
		// random pairs, each master kept to its own half by the top index bit
		for (int k = 0; k < 8; k++) begin
			t = random_bits(1) == 32'd1;
			for (int m = 0; m < 2; m++) begin
				w = random_bits(1) == 32'd1;
				a = bus_pkg::addr_t'(random_bits(`BUS_ADDR_W));
				a[idx_w-1] = m[0];
				d = random_bits(`BUS_DATA_W);
				add_entry(m[0], w, a, d, t && (m == 0));
			end
		end
		// final sweep reads every word back through its owning master
		for (int k = 0; k < `BUS_MEM_WORDS; k++) begin
			a = bus_pkg::addr_t'(k);
			add_entry(a[idx_w-1], 1'b0, a, '0, 1'b0);
		end
	endtask

	task automatic drive_cmd(input entry_t e, input logic valid);
		if (e.master) begin
			m1_cmd_valid = valid;
			m1_cmd_write = e.write;
			m1_cmd_addr = e.addr;
			m1_cmd_wdata = e.wdata;
		end else begin
			m0_cmd_valid = valid;
			m0_cmd_write = e.write;
			m0_cmd_addr = e.addr;
			m0_cmd_wdata = e.wdata;
		end
	endtask

	task automatic run_single(input int i);
		entry_t e;
		bus_pkg::data_t expected;
		e = entries[i];
		while (busy_of(e.master)) @(negedge clk);
		expected = model_mem[e.addr[idx_w-1:0]];
		if (e.write) model_mem[e.addr[idx_w-1:0]] = e.wdata;
		drive_cmd(e, 1'b1);
		@(negedge clk);
		drive_cmd(e, 1'b0);
		while (!done_of(e.master)) @(negedge clk);
		if (!e.write) check_data($sformatf("m%0d_rdata", e.master), rdata_of(e.master), expected);
		last_owner = e.master;
	endtask

	task automatic run_pair(input int i);
		entry_t a;
		entry_t b;
		bus_pkg::data_t exp_a;
		bus_pkg::data_t exp_b;
		logic first;
		logic first_write;
		logic got_a;
		logic got_b;
		logic grant_seen;
		logic retry_seen;
		a = entries[i];
		b = entries[i + 1];
		// on a tie the master that did not own the bus last is granted first
		first = !last_owner;
		first_write = (a.master == first) ? a.write : b.write;
		exp_a = model_mem[a.addr[idx_w-1:0]];
		exp_b = model_mem[b.addr[idx_w-1:0]];
		if (a.write) model_mem[a.addr[idx_w-1:0]] = a.wdata;
		if (b.write) model_mem[b.addr[idx_w-1:0]] = b.wdata;
		while (busy_of(a.master) || busy_of(b.master)) @(negedge clk);
		drive_cmd(a, 1'b1);
		drive_cmd(b, 1'b1);
		@(negedge clk);
		drive_cmd(a, 1'b0);
		drive_cmd(b, 1'b0);
		got_a = 1'b0;
		got_b = 1'b0;
		grant_seen = 1'b0;
		retry_seen = 1'b0;
		while (!(got_a && got_b)) begin
			if (!grant_seen && (bg0 || bg1)) begin
				check_bit("bg0 on first tied grant", bg0, !first);
				grant_seen = 1'b1;
			end
			if (artry) retry_seen = 1'b1;
			if (done_of(a.master)) begin
				if (!a.write) check_data($sformatf("m%0d_rdata", a.master), rdata_of(a.master), exp_a);
				got_a = 1'b1;
			end
			if (done_of(b.master)) begin
				if (!b.write) check_data($sformatf("m%0d_rdata", b.master), rdata_of(b.master), exp_b);
				got_b = 1'b1;
			end
			@(negedge clk);
		end
		// the winning write is still settling when the other tenure gets its aack
		if (first_write) check_bit("artry after tied write", retry_seen, 1'b1);
	endtask

	// grants stay exclusive and only reach a master with a transaction open
	always @(negedge clk) begin
		if (!rst) begin
			check_bit("bg0 & bg1", bg0 & bg1, 1'b0);
			check_bit("bg0 while m0 idle", bg0 & !m0_busy, 1'b0);
			check_bit("bg1 while m1 idle", bg1 & !m1_busy, 1'b0);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the table did not finish within %0d cycles", timeout_cycles);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		cycle_count = 0;
		m0_cmd_valid = 1'b0;
		m0_cmd_write = 1'b0;
		m0_cmd_addr = '0;
		m0_cmd_wdata = '0;
		m1_cmd_valid = 1'b0;
		m1_cmd_write = 1'b0;
		m1_cmd_addr = '0;
		m1_cmd_wdata = '0;
		lfsr_state = 32'h38b4_732a;
		// idle_1 after reset, so master 1 counts as the last owner
		last_owner = 1'b1;
		entry_count = 0;
		for (int k = 0; k < `BUS_MEM_WORDS; k++) begin
			model_mem[k] = '0;
		end
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_bit("bg0", bg0, 1'b0);
		check_bit("bg1", bg1, 1'b0);
		check_bit("ts", ts, 1'b0);
		check_bit("artry", artry, 1'b0);
		check_bit("m0_busy", m0_busy, 1'b0);
		check_bit("m1_busy", m1_busy, 1'b0);
		check_bit("m0_done", m0_done, 1'b0);
		check_bit("m1_done", m1_done, 1'b0);
		i = 0;
		while (i < entry_count) begin
			if (entries[i].together && (i + 1 < entry_count)) begin
				run_pair(i);
				i = i + 2;
			end else begin
				run_single(i);
				i = i + 1;
			end
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/bus_pkg.sv
src/addr_arbiter.sv
src/data_arbiter.sv
src/bus_master.sv
src/bus_target.sv
src/bus_top.sv
bench/tb_bus_top.sv
